// ==== build.f ====
+incdir+hw
hw/mem_pkg.sv
hw/icache.sv
hw/mem_ctrl.sv
hw/mem_subsys.sv
bench/mem_subsys_checker.sv
bench/tb_mem_subsys.sv

// ==== Makefile ====
# Verilator build and run of the memory subsystem testbench

TOP = tb_mem_subsys
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -sv -f build.f --top-module $(TOP) -Mdir obj_dir

run: compile
	-obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "run reported a failure"; exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG) || (echo "run ended early"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_mem_subsys.sv ====
/* memory subsystem testbench */

`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module tb_mem_subsys;

  import mem_pkg::*;

  localparam int CLK_PERIOD      = 20;
  localparam int RAM_BYTES       = 131072;
  localparam int NUM_TESTS       = 6;
  localparam int CYCLES_PER_TEST = 2000;
  localparam int DONE_LIMIT      = 200;

  logic             clk_in;
  logic             reset;
  logic             rdy_in;
  logic             flush;
  logic             fetch_req;
  fetch_req_t       fetch_pc;
  logic [`XLEN-1:0] fetch_instr;
  logic             fetch_done;
  logic             data_req;
  data_req_t        data_cmd;
  logic [`XLEN-1:0] data_rdata;
  logic             data_done;
  logic [7:0]       mem_din;
  logic [7:0]       mem_dout;
  logic [`XLEN-1:0] mem_a;
  logic             mem_wr;
  logic             io_buffer_full;

  // RAM model, and the contents the tests expect to read back
  logic [7:0] ram [RAM_BYTES];
  logic [7:0] shadow [RAM_BYTES];
  int         io_writes;
  logic [7:0] io_byte;

  integer seed;
  int     test_num;
  int     test_errors;
  int     errors;
  int     tests_failed;

  mem_subsys mem_subsys_inst (.*);

  initial clk_in = 1'b0;
  always #(CLK_PERIOD / 2) clk_in = ~clk_in;

  function automatic logic [7:0] preload_byte(logic [31:0] addr);
    logic [31:0] v;
    v = addr * 32'd7 + 32'd3;
    // upper bytes folded in so every address bit matters
    return v[7:0] ^ v[15:8] ^ v[23:16];
  endfunction

  function automatic int size_bytes(access_size_e size);
    case (size)
      size_byte: return 1;
      size_half: return 2;
      default:   return 4;
    endcase
  endfunction

  // little-endian value at addr, extended like a load of that size
  function automatic logic [31:0] expect_load(access_size_e size, logic sign_ext,
                                              logic [31:0] addr);
    logic [31:0] w;
    logic [31:0] a;
    for (int k = 0; k < 4; k++) begin
      a = addr + k;
      w[8*k +: 8] = shadow[a[16:0]];
    end
    case (size)
      size_byte: return {{24{sign_ext & w[7]}}, w[7:0]};
      size_half: return {{16{sign_ext & w[15]}}, w[15:0]};
      default:   return w;
    endcase
  endfunction

  function automatic void apply_store(access_size_e size, logic [31:0] addr,
                                      logic [31:0] wdata);
    logic [31:0] a;
    for (int k = 0; k < size_bytes(size); k++) begin
      a = addr + k;
      shadow[a[16:0]] = wdata[8*k +: 8];
    end
  endfunction

  initial begin
    for (int i = 0; i < RAM_BYTES; i++) begin
      ram[17'(i)]    <= preload_byte(i);
      shadow[17'(i)] = preload_byte(i);
    end
    io_writes <= 0;
    mem_din   <= 8'h00;
  end

  // read data one cycle after the address; I/O page writes are logged
  always @(posedge clk_in) begin
    if (rdy_in) begin
      if (mem_a[17:16] == `IO_PAGE_SEL) begin
        mem_din <= 8'h00;
        if (mem_wr) begin
          io_writes <= io_writes + 1;
          io_byte   <= mem_dout;
        end
      end else begin
        mem_din <= ram[mem_a[16:0]];
        if (mem_wr) begin
          ram[mem_a[16:0]] <= mem_dout;
        end
      end
    end
  end

  initial begin
    #(NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
    $display("watchdog expired, a test hung after %0d tests", test_num);
    $display("Simulation failed");
    $finish;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t: %s read %h, expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("at %0t: %s", $time, msg);
      test_errors++;
    end
  endtask

  // called 1 ns after a rising edge, returns 1 ns after one
  task automatic do_fetch(input logic [31:0] pc, output logic [31:0] instr,
                          output int cycles);
    logic seen;
    seen         = 1'b0;
    cycles       = 0;
    fetch_pc.pc  = pc;
    fetch_req    = 1'b1;
    while (!seen && cycles < DONE_LIMIT) begin
      @(posedge clk_in);
      cycles++;
      @(negedge clk_in);
      seen = fetch_done;
    end
    instr = fetch_instr;
    check_true(seen, $sformatf("fetch of pc %h never completed", pc));
    @(posedge clk_in);
    #1;
    fetch_req = 1'b0;
  endtask

  task automatic do_data(input logic write, input access_size_e size, input logic sign_ext,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output int cycles);
    logic seen;
    seen              = 1'b0;
    cycles            = 0;
    data_cmd.write    = write;
    data_cmd.size     = size;
    data_cmd.sign_ext = sign_ext;
    data_cmd.addr     = addr;
    data_cmd.wdata    = wdata;
    data_req          = 1'b1;
    while (!seen && cycles < DONE_LIMIT) begin
      @(posedge clk_in);
      cycles++;
      @(negedge clk_in);
      seen = data_done;
    end
    rdata = data_rdata;
    check_true(seen, $sformatf("data access at %h never completed", addr));
    @(posedge clk_in);
    #1;
    data_req = 1'b0;
  endtask

  task automatic finish_test(input string name);
    test_num++;
    if (test_errors == 0) begin
      $display("test %0d %s: ok", test_num, name);
    end else begin
      $display("test %0d %s: FAIL with %0d errors", test_num, name, test_errors);
      tests_failed++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  initial begin
    logic [31:0]  pc;
    logic [31:0]  addr;
    logic [31:0]  base;
    logic [31:0]  wdata;
    logic [31:0]  instr;
    logic [31:0]  rdata;
    access_size_e sz;
    int           lat;
    int           lat2;
    int           start;
    int unsigned  violations;
    seed           = 32'hafa0;
    test_num       = 0;
    test_errors    = 0;
    errors         = 0;
    tests_failed   = 0;
    reset          = 1'b1;
    rdy_in         = 1'b1;
    flush          = 1'b0;
    fetch_req      = 1'b0;
    fetch_pc       = '0;
    data_req       = 1'b0;
    data_cmd       = '0;
    io_buffer_full = 1'b0;
    repeat (5) @(posedge clk_in);
    #1;
    reset = 1'b0;
    @(posedge clk_in);
    #1;

    pc = 32'h0000_0100;
    do_fetch(pc, instr, lat);
    check_value("fetch miss", instr, expect_load(size_word, 1'b0, pc));
    do_fetch(pc, instr, lat);
    check_value("fetch hit", instr, expect_load(size_word, 1'b0, pc));
    check_true(lat == 1, $sformatf("fetch hit took %0d cycles instead of 1", lat));
    finish_test("fetch miss then hit");

    for (int s = 0; s < 3; s++) begin
      for (int n = 0; n < 8; n++) begin
        sz   = access_size_e'(s[1:0]);
        addr = $random(seed) & 32'h0001_FFFF;
        addr = addr & ~(32'(size_bytes(sz)) - 32'd1);
        do_data(1'b0, sz, n[0], addr, 32'h0, rdata, lat);
        check_value("load", rdata, expect_load(sz, n[0], addr));
        check_true(lat >= size_bytes(sz) + 2, "load finished too early");
      end
    end
    finish_test("loads of each size");

    for (int s = 0; s < 3; s++) begin
      sz    = access_size_e'(s[1:0]);
      base  = 32'h0001_0000 | ($random(seed) & 32'h0000_FFFC);
      addr  = base + (($random(seed) & 32'h3) & ~(32'(size_bytes(sz)) - 32'd1));
      wdata = $random(seed);
      apply_store(sz, addr, wdata);
      fork
        do_data(1'b1, sz, 1'b0, addr, wdata, rdata, lat);
        begin
          // core frozen for a few cycles in the middle of the word store
          if (sz == size_word) begin
            repeat (2) @(posedge clk_in);
            #1 rdy_in = 1'b0;
            repeat (3) @(posedge clk_in);
            #1 rdy_in = 1'b1;
          end
        end
      join
      do_data(1'b0, size_word, 1'b0, base, 32'h0, rdata, lat);
      check_value("word after store", rdata, expect_load(size_word, 1'b0, base));
    end
    finish_test("store then word load");

    io_buffer_full = 1'b1;
    start          = io_writes;
    wdata          = $random(seed);
    fork
      do_data(1'b1, size_byte, 1'b0, `IO_DATA_ADDR, wdata, rdata, lat);
      begin
        repeat (10) begin
          @(negedge clk_in);
          check_true(!data_done && io_writes == start, "I/O store went out while full");
        end
        @(posedge clk_in);
        #1 io_buffer_full = 1'b0;
      end
    join
    check_true(io_writes == start + 1, $sformatf("%0d I/O writes seen", io_writes - start));
    check_value("I/O byte", {24'h0, io_byte}, {24'h0, wdata[7:0]});
    finish_test("I/O store under back-pressure");

    pc   = 32'h0000_0240;
    addr = $random(seed) & 32'h0001_FFFC;
    fork
      do_fetch(pc, instr, lat);
      do_data(1'b0, size_word, 1'b0, addr, 32'h0, rdata, lat2);
    join
    check_value("load beside miss", rdata, expect_load(size_word, 1'b0, addr));
    check_value("fetch beside load", instr, expect_load(size_word, 1'b0, pc));
    check_true(lat2 < lat, "load did not finish ahead of the fetch refill");
    finish_test("load during fetch miss");

    pc          = 32'h0000_0380;
    fetch_pc.pc = pc;
    fetch_req   = 1'b1;
    @(posedge clk_in);
    #1;
    flush     = 1'b1;
    fetch_req = 1'b0;
    @(posedge clk_in);
    #1;
    flush = 1'b0;
    repeat (30) begin
      @(negedge clk_in);
      check_true(!fetch_done, "fetch_done came for a flushed fetch");
    end
    @(posedge clk_in);
    #1;
    do_fetch(pc, instr, lat);
    check_value("fetch after flush", instr, expect_load(size_word, 1'b0, pc));
    finish_test("flush during miss");

    violations = mem_subsys_inst.protocol_checker_inst.violations;
    $display("%0d tests, %0d failed, %0d errors, %0d protocol violations",
             test_num, tests_failed, errors, violations);
    if (errors == 0 && violations == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== bench/mem_subsys_checker.sv ====
/* memory bus protocol checks */

`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsys_checker (
  input logic             clk_in,
  input logic             reset,
  input logic             rdy_in,
  input logic             fetch_req,
  input logic             fetch_done,
  input logic             data_req,
  input logic             data_done,
  input logic             refill_req,
  input logic             refill_done,
  input logic [`XLEN-1:0] mem_a,
  input logic             mem_wr,
  input logic             io_buffer_full
);

  int unsigned violations;

  initial violations = 0;

  // bus is quiet while the core is frozen
  frozen_no_write: assert property (@(posedge clk_in) !rdy_in |-> !mem_wr)
    else begin
      $error("mem_wr high while rdy_in is low");
      violations++;
    end

  io_backpressure: assert property (@(posedge clk_in)
      (mem_wr && mem_a[17:16] == `IO_PAGE_SEL) |-> !io_buffer_full)
    else begin
      $error("I/O page write while io_buffer_full is high");
      violations++;
    end

  fetch_done_req: assert property (@(posedge clk_in) disable iff (reset)
      fetch_done |-> fetch_req)
    else begin
      $error("fetch_done without fetch_req");
      violations++;
    end

  data_done_req: assert property (@(posedge clk_in) disable iff (reset)
      data_done |-> data_req)
    else begin
      $error("data_done without data_req");
      violations++;
    end

  refill_done_req: assert property (@(posedge clk_in) disable iff (reset)
      refill_done |-> refill_req)
    else begin
      $error("refill_done without refill_req");
      violations++;
    end

  // outputs idle right after reset
  reset_idle: assert property (@(posedge clk_in) reset |=>
      (!fetch_done && !data_done && !refill_done && !refill_req && !mem_wr))
    else begin
      $error("handshake or write active after reset");
      violations++;
    end

endmodule

bind mem_subsys mem_subsys_checker protocol_checker_inst (
  .clk_in         (clk_in),
  .reset          (reset),
  .rdy_in         (rdy_in),
  .fetch_req      (fetch_req),
  .fetch_done     (fetch_done),
  .data_req       (data_req),
  .data_done      (data_done),
  .refill_req     (refill_req),
  .refill_done    (refill_done),
  .mem_a          (mem_a),
  .mem_wr         (mem_wr),
  .io_buffer_full (io_buffer_full)
);

`default_nettype wire

// ==== hw/mem_subsys.sv ====
/* memory subsystem top level */

`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module mem_subsys (
  input  logic                clk_in,
  input  logic                reset,
  input  logic                rdy_in,
  input  logic                flush,

  // instruction fetch
  input  logic                fetch_req,
  input  mem_pkg::fetch_req_t fetch_pc,
  output logic [`XLEN-1:0]    fetch_instr,
  output logic                fetch_done,

  // loads and stores
  input  logic                data_req,
  input  mem_pkg::data_req_t  data_cmd,
  output logic [`XLEN-1:0]    data_rdata,
  output logic                data_done,

  // memory bus
  input  logic [7:0]          mem_din,
  output logic [7:0]          mem_dout,
  output logic [`XLEN-1:0]    mem_a,
  output logic                mem_wr,
  input  logic                io_buffer_full
);

  import mem_pkg::*;

  // icache and mem_ctrl
  logic             refill_req;
  refill_req_t      refill_addr;
  logic [`XLEN-1:0] refill_word;
  logic             refill_done;

  icache icache_inst (
    .clk_in      (clk_in),
    .reset       (reset),
    .rdy_in      (rdy_in),
    .flush       (flush),
    .fetch_req   (fetch_req),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .fetch_done  (fetch_done),
    .refill_req  (refill_req),
    .refill_addr (refill_addr),
    .refill_word (refill_word),
    .refill_done (refill_done)
  );

  mem_ctrl mem_ctrl_inst (
    .clk_in         (clk_in),
    .reset          (reset),
    .rdy_in         (rdy_in),
    .data_req       (data_req),
    .data_cmd       (data_cmd),
    .data_rdata     (data_rdata),
    .data_done      (data_done),
    .refill_req     (refill_req),
    .refill_addr    (refill_addr),
    .refill_word    (refill_word),
    .refill_done    (refill_done),
    .mem_din        (mem_din),
    .mem_dout       (mem_dout),
    .mem_a          (mem_a),
    .mem_wr         (mem_wr),
    .io_buffer_full (io_buffer_full)
  );

endmodule

`default_nettype wire

// ==== hw/mem_ctrl.sv ====
/* memory controller, byte-serial bus sequencer */

`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module mem_ctrl (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 rdy_in,

  // data port
  input  logic                 data_req,
  input  mem_pkg::data_req_t   data_cmd,
  output logic [`XLEN-1:0]     data_rdata,
  output logic                 data_done,

  // refill channel from the icache
  input  logic                 refill_req,
  input  mem_pkg::refill_req_t refill_addr,
  output logic [`XLEN-1:0]     refill_word,
  output logic                 refill_done,

  // byte-wide memory bus
  input  logic [7:0]           mem_din,
  output logic [7:0]           mem_dout,
  output logic [`XLEN-1:0]     mem_a,
  output logic                 mem_wr,
  input  logic                 io_buffer_full
);

  import mem_pkg::*;

  // sequencer state
  logic             busy_q;
  logic             src_refill_q;
  logic [2:0]       cnt_q;

  // latched request and data shift register
  data_req_t        req_q;
  logic [`XLEN-1:0] word_q;
  logic [`XLEN-1:0] result_q;

  logic [2:0]       nbytes;
  mem_addr_u        cur_addr;
  logic             issuing;
  logic             io_stall;
  logic             last_step;
  logic             grant_data;
  logic             grant_refill;
  logic [`XLEN-1:0] shifted;
  logic [`XLEN-1:0] extended;

  always_comb begin
    case (req_q.size)
      size_byte: nbytes = 3'd1;
      size_half: nbytes = 3'd2;
      default:   nbytes = 3'd4;
    endcase
  end

  // arbiter, only while idle; data beats a waiting refill
  assign grant_data   = !busy_q && data_req && !data_done;
  assign grant_refill = !busy_q && !grant_data && refill_req && !refill_done;

  // step cnt_q puts byte cnt_q on the bus, read bytes come back one step later
  assign cur_addr  = req_q.addr + {{(`XLEN-3){1'b0}}, cnt_q};
  assign issuing   = busy_q && (cnt_q < nbytes);
  assign last_step = busy_q && (cnt_q == nbytes);

  // uart writes wait for room in the output buffer
  assign io_stall = issuing && req_q.write && (cur_addr.bus.page_sel == `IO_PAGE_SEL)
                    && io_buffer_full;

  // idle bus shows address 0 so no I/O read happens by accident
  assign mem_a    = issuing ? cur_addr : '0;
  assign mem_dout = word_q[7:0];
  assign mem_wr   = issuing && req_q.write && !io_stall && rdy_in;

  // little endian, newest byte enters at the top
  assign shifted = {mem_din, word_q[`XLEN-1:8]};

  // short loads end up in the upper bits of the shift register
  always_comb begin
    case (req_q.size)
      size_byte: begin
        extended = {{(`XLEN-8){req_q.sign_ext && shifted[`XLEN-1]}},
                    shifted[`XLEN-1 -: 8]};
      end
      size_half: begin
        extended = {{(`XLEN-16){req_q.sign_ext && shifted[`XLEN-1]}},
                    shifted[`XLEN-1 -: 16]};
      end
      default: begin
        extended = shifted;
      end
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (reset) begin
      busy_q       <= 1'b0;
      src_refill_q <= 1'b0;
      cnt_q        <= '0;
      data_done    <= 1'b0;
      refill_done  <= 1'b0;
    end else if (rdy_in) begin
      data_done   <= 1'b0;
      refill_done <= 1'b0;
      if (grant_data || grant_refill) begin
        busy_q       <= 1'b1;
        src_refill_q <= grant_refill;
        cnt_q        <= '0;
      end else if (last_step) begin
        busy_q      <= 1'b0;
        data_done   <= !src_refill_q;
        refill_done <= src_refill_q;
      end else if (busy_q && !io_stall) begin
        cnt_q <= cnt_q + 3'd1;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (grant_data) begin
        req_q  <= data_cmd;
        word_q <= data_cmd.wdata;
      end else if (grant_refill) begin
        // a refill is an unsigned word load
        req_q <= '{write: 1'b0, size: size_word, sign_ext: 1'b0,
                   addr: refill_addr.addr, wdata: '0};
      end else if (last_step) begin
        result_q <= extended;
      end else if (busy_q && !io_stall && (req_q.write || (cnt_q != 3'd0))) begin
        // stores shift out the next byte, loads shift in the returned one
        word_q <= shifted;
      end
    end
  end

  assign data_rdata  = result_q;
  assign refill_word = result_q;

endmodule

`default_nettype wire

// ==== hw/icache.sv ====
/* direct-mapped instruction cache */

`timescale 1ns/10ps
`default_nettype none

`include "mem_defs.svh"

module icache (
  input  logic                 clk_in,
  input  logic                 reset,
  input  logic                 rdy_in,
  input  logic                 flush,

  // fetch port
  input  logic                 fetch_req,
  input  mem_pkg::fetch_req_t  fetch_pc,
  output logic [`XLEN-1:0]     fetch_instr,
  output logic                 fetch_done,

  // refill channel to the memory controller
  output logic                 refill_req,
  output mem_pkg::refill_req_t refill_addr,
  input  logic [`XLEN-1:0]     refill_word,
  input  logic                 refill_done
);

  import mem_pkg::*;

  localparam int unsigned LINES = `ICACHE_LINES;

  logic [LINES-1:0]          valid_q;
  logic [`ICACHE_TAG_W-1:0]  tag_arr [LINES];
  logic [`XLEN-1:0]          data_arr [LINES];

  mem_addr_u pc_addr;
  mem_addr_u fill_addr;
  logic      hit;
  logic      accept;
  logic      fill_ok;
  // miss was flushed, its refill word gets thrown away
  logic      drop_q;

  assign pc_addr   = fetch_pc.pc;
  assign fill_addr = refill_addr.addr;

  assign hit = valid_q[pc_addr.ic.index] && (tag_arr[pc_addr.ic.index] == pc_addr.ic.tag);

  // new lookup only when nothing is pending and the last answer is gone
  assign accept = fetch_req && !fetch_done && !refill_req && !flush;

  assign fill_ok = refill_req && refill_done && !drop_q && !flush;

  always_ff @(posedge clk_in) begin
    if (reset) begin
      valid_q    <= '0;
      fetch_done <= 1'b0;
      refill_req <= 1'b0;
      drop_q     <= 1'b0;
    end else if (rdy_in) begin
      fetch_done <= 1'b0;
      if (refill_req) begin
        // keep the request up until the controller ends it
        if (flush) begin
          drop_q <= 1'b1;
        end
        if (refill_done) begin
          refill_req <= 1'b0;
          drop_q     <= 1'b0;
          if (fill_ok) begin
            valid_q[fill_addr.ic.index] <= 1'b1;
            fetch_done                  <= 1'b1;
          end
        end
      end else if (accept && !hit) begin
        refill_req <= 1'b1;
      end else if (accept) begin
        fetch_done <= 1'b1;
      end
    end
  end

  // arrays and returned word
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (fill_ok) begin
        tag_arr[fill_addr.ic.index]  <= fill_addr.ic.tag;
        data_arr[fill_addr.ic.index] <= refill_word;
        fetch_instr                  <= refill_word;
      end else if (accept) begin
        fetch_instr      <= data_arr[pc_addr.ic.index];
        // word aligned address for a possible refill
        refill_addr.addr <= {pc_addr.ic.tag, pc_addr.ic.index, {`ICACHE_OFFSET_W{1'b0}}};
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/mem_pkg.sv ====
/* memory subsystem types */

`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

  // width of a data access
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  // data port command, 68 bits
  typedef struct packed {
    logic               write;
    access_size_e       size;
    logic               sign_ext;
    logic [`XLEN-1:0]   addr;
    logic [`XLEN-1:0]   wdata;
  } data_req_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
  } fetch_req_t;

  // word address of a cache refill
  typedef struct packed {
    logic [`XLEN-1:0] addr;
  } refill_req_t;

  typedef struct packed {
    logic [`ICACHE_TAG_W-1:0]    tag;
    logic [`ICACHE_INDEX_W-1:0]  index;
    logic [`ICACHE_OFFSET_W-1:0] offset;
  } icache_addr_t;

  typedef struct packed {
    logic [`XLEN-`PAGE_SEL_LSB-3:0] upper;
    logic [1:0]                     page_sel;
    logic [`PAGE_SEL_LSB-1:0]       byte_addr;
  } bus_addr_t;

  // one address word, seen by the cache or by the bus sequencer
  typedef union packed {
    icache_addr_t ic;
    bus_addr_t    bus;
  } mem_addr_u;

endpackage

`default_nettype wire

// ==== hw/mem_defs.svh ====
/* memory subsystem constants */

`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// data and address width
`define XLEN 32

// instruction cache geometry, one word per line
`define ICACHE_LINES    64
`define ICACHE_OFFSET_W 2
`define ICACHE_INDEX_W  ($clog2(`ICACHE_LINES))
`define ICACHE_TAG_W    (`XLEN - `ICACHE_INDEX_W - `ICACHE_OFFSET_W)

// lowest address bit of the page select field
`define PAGE_SEL_LSB 16

// mem_a[17:16] == 2'b11 marks the I/O page
`define IO_PAGE_SEL 2'b11

// uart byte in/out
`define IO_DATA_ADDR 32'h30000
// clock counter on read, program stop on write
`define IO_CTRL_ADDR 32'h30004

`endif
